// ==== rtl/lc4_defines.svh ====
`ifndef LC4_DEFINES_SVH
`define LC4_DEFINES_SVH

// data word and address width
`define LC4_XLEN 16

// register select width, eight general purpose registers
`define LC4_REG_SEL_W 3
`define LC4_NUM_REGS 8

// first fetch address after reset
`define LC4_RESET_PC 16'h8200

// run control register map
`define LC4_APB_ADDR_W 4
`define LC4_REG_CTRL 4'h0
`define LC4_REG_STEP 4'h4
`define LC4_REG_RETIRED 4'h8

`endif

// ==== rtl/lc4_pkg.sv ====
`include "lc4_defines.svh"

package lc4_pkg;

    // opcode groups still decoded, everything else is a no-op
    typedef enum logic [3:0] {
        OP_BR    = 4'b0000,
        OP_ARITH = 4'b0001,
        OP_LOGIC = 4'b0101,
        OP_LDR   = 4'b0110,
        OP_STR   = 4'b0111,
        OP_CONST = 4'b1001,
        OP_JMP   = 4'b1100
    } opcode_e;

    // stall code carried alongside every stage, seen on the trace
    typedef enum logic [1:0] {
        NONE  = 2'd0,
        PIPE  = 2'd1,
        FLUSH = 2'd2,
        LOAD  = 2'd3
    } stall_e;

    typedef struct packed {
        logic [`LC4_REG_SEL_W-1:0] rs_sel;
        logic [`LC4_REG_SEL_W-1:0] rt_sel;
        logic [`LC4_REG_SEL_W-1:0] rd_sel;
        logic                      rs_re;
        logic                      rt_re;
        logic                      rf_we;
        logic                      nzp_we;
        logic                      is_load;
        logic                      is_store;
        logic                      is_branch;
        logic                      is_jump;
        logic [`LC4_XLEN-1:0]      insn;
    } decoded_t;

endpackage

// ==== rtl/lc4_ifs.sv ====
`include "lc4_defines.svh"

// two read ports and one write port of the register file
interface rf_if;
    logic [`LC4_REG_SEL_W-1:0] rs_sel;
    logic [`LC4_REG_SEL_W-1:0] rt_sel;
    logic [`LC4_XLEN-1:0]      rs_data;
    logic [`LC4_XLEN-1:0]      rt_data;
    logic                      wr_we;
    logic [`LC4_REG_SEL_W-1:0] wr_sel;
    logic [`LC4_XLEN-1:0]      wr_data;

    modport core (output rs_sel, rt_sel, wr_we, wr_sel, wr_data, input rs_data, rt_data);
    modport regfile (input rs_sel, rt_sel, wr_we, wr_sel, wr_data, output rs_data, rt_data);
endinterface

// APB without wait states
interface apb_if;
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    logic [`LC4_APB_ADDR_W-1:0] paddr;
    logic [`LC4_XLEN-1:0]       pwdata;
    logic [`LC4_XLEN-1:0]       prdata;
    logic                       pready;
    logic                       pslverr;

    modport slave (input psel, penable, pwrite, paddr, pwdata, output prdata, pready, pslverr);
endinterface

// ==== rtl/lc4_decoder.sv ====
`include "lc4_defines.svh"

module lc4_decoder (
    input  logic [`LC4_XLEN-1:0] i_insn,
    output lc4_pkg::decoded_t    o_dec
);

    always_comb begin
        o_dec           = '0;
        o_dec.insn      = i_insn;
        o_dec.rs_sel    = i_insn[8:6];
        o_dec.rt_sel    = i_insn[2:0];
        o_dec.rd_sel    = i_insn[11:9];

        case (i_insn[15:12])
            lc4_pkg::OP_BR: begin
                // nzp of 000 is the plain NOP
                o_dec.is_branch = |i_insn[11:9];
            end
            lc4_pkg::OP_ARITH: begin
                // ADD, SUB and ADD-immediate only
                if (i_insn[5] || i_insn[5:3] == 3'b000 || i_insn[5:3] == 3'b010) begin
                    o_dec.rs_re  = 1'b1;
                    o_dec.rt_re  = !i_insn[5];
                    o_dec.rf_we  = 1'b1;
                    o_dec.nzp_we = 1'b1;
                end
            end
            lc4_pkg::OP_LOGIC: begin
                o_dec.rs_re  = 1'b1;
                // NOT and the immediate form have no second operand
                o_dec.rt_re  = !i_insn[5] && i_insn[4:3] != 2'b01;
                o_dec.rf_we  = 1'b1;
                o_dec.nzp_we = 1'b1;
            end
            lc4_pkg::OP_LDR: begin
                o_dec.rs_re   = 1'b1;
                o_dec.rf_we   = 1'b1;
                o_dec.nzp_we  = 1'b1;
                o_dec.is_load = 1'b1;
            end
            lc4_pkg::OP_STR: begin
                // store data sits in the rd field
                o_dec.rs_re    = 1'b1;
                o_dec.rt_re    = 1'b1;
                o_dec.rt_sel   = i_insn[11:9];
                o_dec.is_store = 1'b1;
            end
            lc4_pkg::OP_CONST: begin
                o_dec.rf_we  = 1'b1;
                o_dec.nzp_we = 1'b1;
            end
            lc4_pkg::OP_JMP: begin
                // only the PC-relative form, JMPR stays a no-op
                o_dec.is_jump = i_insn[11];
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== rtl/lc4_alu.sv ====
`include "lc4_defines.svh"

module lc4_alu (
    input  lc4_pkg::decoded_t    i_dec,
    input  logic [`LC4_XLEN-1:0] i_pc,
    input  logic [`LC4_XLEN-1:0] i_rs_data,
    input  logic [`LC4_XLEN-1:0] i_rt_data,
    output logic [`LC4_XLEN-1:0] o_result
);
    logic [`LC4_XLEN-1:0] imm5;
    logic [`LC4_XLEN-1:0] imm6;
    logic [`LC4_XLEN-1:0] imm9;
    logic [`LC4_XLEN-1:0] imm11;
    logic [`LC4_XLEN-1:0] pc_inc;

    assign imm5   = {{(`LC4_XLEN-5){i_dec.insn[4]}}, i_dec.insn[4:0]};
    assign imm6   = {{(`LC4_XLEN-6){i_dec.insn[5]}}, i_dec.insn[5:0]};
    assign imm9   = {{(`LC4_XLEN-9){i_dec.insn[8]}}, i_dec.insn[8:0]};
    assign imm11  = {{(`LC4_XLEN-11){i_dec.insn[10]}}, i_dec.insn[10:0]};
    assign pc_inc = i_pc + 1'b1;

    always_comb begin
        case (i_dec.insn[15:12])
            lc4_pkg::OP_ARITH: begin
                if (i_dec.insn[5]) o_result = i_rs_data + imm5;
                else if (i_dec.insn[4:3] == 2'b10) o_result = i_rs_data - i_rt_data;
                else o_result = i_rs_data + i_rt_data;
            end
            lc4_pkg::OP_LOGIC: begin
                if (i_dec.insn[5]) o_result = i_rs_data & imm5;
                else begin
                    case (i_dec.insn[4:3])
                        2'b00:   o_result = i_rs_data & i_rt_data;
                        2'b01:   o_result = ~i_rs_data;
                        2'b10:   o_result = i_rs_data | i_rt_data;
                        default: o_result = i_rs_data ^ i_rt_data;
                    endcase
                end
            end
            // effective address for both memory ops
            lc4_pkg::OP_LDR, lc4_pkg::OP_STR: o_result = i_rs_data + imm6;
            lc4_pkg::OP_CONST: o_result = imm9;
            lc4_pkg::OP_BR:    o_result = pc_inc + imm9;
            lc4_pkg::OP_JMP:   o_result = pc_inc + imm11;
            default:           o_result = '0;
        endcase
    end

endmodule

// ==== rtl/lc4_regfile.sv ====
`include "lc4_defines.svh"

module lc4_regfile (
    input logic   gwe,
    input logic   i_rst,
    rf_if.regfile rf
);
    logic [`LC4_XLEN-1:0] regs [`LC4_NUM_REGS];

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            for (int i = 0; i < `LC4_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rf.wr_we) begin
            regs[rf.wr_sel] <= rf.wr_data;
        end
    end

    // writeback in this cycle is seen by decode in the same cycle
    assign rf.rs_data = (rf.wr_we && rf.wr_sel == rf.rs_sel) ? rf.wr_data : regs[rf.rs_sel];
    assign rf.rt_data = (rf.wr_we && rf.wr_sel == rf.rt_sel) ? rf.wr_data : regs[rf.rt_sel];

endmodule

// ==== rtl/lc4_run_ctrl.sv ====
`include "lc4_defines.svh"

module lc4_run_ctrl (
    input  logic gwe,
    input  logic i_rst,
    apb_if.slave apb,
    input  logic i_retire,
    output logic o_advance
);
    logic                 run;
    logic [`LC4_XLEN-1:0] step_cnt;
    logic [`LC4_XLEN-1:0] retired_cnt;
    logic [`LC4_XLEN-1:0] rd_data;
    logic                 mapped;
    logic                 wr_access;

    // free-run or a pending step lets the core move
    assign o_advance = run || (step_cnt != '0);
    assign wr_access = apb.psel && apb.penable && apb.pwrite;

    always_comb begin
        mapped  = 1'b1;
        rd_data = '0;
        case (apb.paddr)
            `LC4_REG_CTRL:    rd_data = {{(`LC4_XLEN-1){1'b0}}, run};
            `LC4_REG_STEP:    rd_data = step_cnt;
            `LC4_REG_RETIRED: rd_data = retired_cnt;
            default:          mapped  = 1'b0;
        endcase
    end

    assign apb.prdata  = (apb.psel && !apb.pwrite) ? rd_data : '0;
    assign apb.pready  = 1'b1;
    assign apb.pslverr = apb.psel && apb.penable && !mapped;

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            run         <= 1'b0;
            step_cnt    <= '0;
            retired_cnt <= '0;
        end else begin
            if (wr_access && apb.paddr == `LC4_REG_CTRL) begin
                run <= apb.pwdata[0];
            end
            // a new step count replaces whatever is left
            if (wr_access && apb.paddr == `LC4_REG_STEP) begin
                step_cnt <= apb.pwdata;
            end else if (!run && step_cnt != '0) begin
                step_cnt <= step_cnt - 1'b1;
            end
            if (i_retire) begin
                retired_cnt <= retired_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== rtl/lc4_pipeline.sv ====
`include "lc4_defines.svh"

module lc4_pipeline (
    input  logic                       gwe,
    input  logic                       i_rst,
    input  logic                       i_advance,
    output logic [`LC4_XLEN-1:0]       o_imem_addr,
    input  logic [`LC4_XLEN-1:0]       i_imem_data,
    output logic [`LC4_XLEN-1:0]       o_dmem_addr,
    input  logic [`LC4_XLEN-1:0]       i_dmem_data,
    output logic                       o_dmem_we,
    output logic [`LC4_XLEN-1:0]       o_dmem_wdata,
    rf_if.core                         rf,
    output logic                       o_retire,
    output logic                       o_trace_valid,
    output logic [1:0]                 o_trace_stall,
    output logic [`LC4_XLEN-1:0]       o_trace_pc,
    output logic [`LC4_XLEN-1:0]       o_trace_insn,
    output logic                       o_trace_rf_we,
    output logic [`LC4_REG_SEL_W-1:0]  o_trace_rf_wsel,
    output logic [`LC4_XLEN-1:0]       o_trace_rf_data
);
    logic [`LC4_XLEN-1:0] pc_f, d_pc, x_pc, m_pc, w_pc;
    logic [`LC4_XLEN-1:0] d_insn;
    lc4_pkg::stall_e      d_stall, x_stall, m_stall, w_stall;
    lc4_pkg::decoded_t    d_dec, x_dec, m_dec, w_dec;
    logic [`LC4_XLEN-1:0] x_rs, x_rt, m_alu, m_rt, w_alu, w_mem;
    logic [`LC4_XLEN-1:0] rs_fwd, rt_fwd, x_result, w_data, store_data;
    logic [2:0]           nzp;
    logic                 flush, load_use;

    function automatic logic [2:0] nzp_of(input logic [`LC4_XLEN-1:0] v);
        return v[`LC4_XLEN-1] ? 3'b100 : (v == '0) ? 3'b010 : 3'b001;
    endfunction

    lc4_decoder u_decoder (.i_insn(d_insn), .o_dec(d_dec));

    lc4_alu u_alu (
        .i_dec     (x_dec),
        .i_pc      (x_pc),
        .i_rs_data (rs_fwd),
        .i_rt_data (rt_fwd),
        .o_result  (x_result)
    );

    assign w_data = w_dec.is_load ? w_mem : w_alu;

    // MX takes priority over WX, the younger result wins
    assign rs_fwd = (m_dec.rf_we && m_dec.rd_sel == x_dec.rs_sel) ? m_alu :
                    (w_dec.rf_we && w_dec.rd_sel == x_dec.rs_sel) ? w_data : x_rs;
    assign rt_fwd = (m_dec.rf_we && m_dec.rd_sel == x_dec.rt_sel) ? m_alu :
                    (w_dec.rf_we && w_dec.rd_sel == x_dec.rt_sel) ? w_data : x_rt;

    // taken branch or jump in execute kills decode and fetch
    assign flush = x_dec.is_jump || (x_dec.is_branch && (x_dec.insn[11:9] & nzp) != 3'b000);

    // store data can still come over WM, the address base cannot
    assign load_use = x_dec.is_load &&
                      ((d_dec.rs_re && d_dec.rs_sel == x_dec.rd_sel) ||
                       (d_dec.rt_re && !d_dec.is_store && d_dec.rt_sel == x_dec.rd_sel) ||
                       d_dec.is_branch);

    assign rf.rs_sel  = d_dec.rs_sel;
    assign rf.rt_sel  = d_dec.rt_sel;
    assign rf.wr_we   = w_dec.rf_we && i_advance;
    assign rf.wr_sel  = w_dec.rd_sel;
    assign rf.wr_data = w_data;

    assign store_data   = (w_dec.rf_we && w_dec.rd_sel == m_dec.rt_sel) ? w_data : m_rt;
    assign o_imem_addr  = pc_f;
    assign o_dmem_addr  = (m_dec.is_load || m_dec.is_store) ? m_alu : '0;
    assign o_dmem_we    = m_dec.is_store && i_advance;
    assign o_dmem_wdata = store_data;

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            pc_f    <= `LC4_RESET_PC;
            d_pc    <= '0;
            d_insn  <= '0;
            d_stall <= lc4_pkg::FLUSH;
            x_pc    <= '0;
            x_dec   <= '0;
            x_stall <= lc4_pkg::FLUSH;
            m_pc    <= '0;
            m_dec   <= '0;
            m_stall <= lc4_pkg::FLUSH;
            w_pc    <= '0;
            w_dec   <= '0;
            w_stall <= lc4_pkg::FLUSH;
            nzp     <= 3'b000;
        end else if (i_advance) begin
            if (flush) begin
                pc_f    <= x_result;
                d_pc    <= '0;
                d_insn  <= '0;
                d_stall <= lc4_pkg::FLUSH;
                x_pc    <= '0;
                x_dec   <= '0;
                x_stall <= lc4_pkg::FLUSH;
            end else if (load_use) begin
                // fetch and decode hold, execute takes a bubble
                x_pc    <= '0;
                x_dec   <= '0;
                x_stall <= lc4_pkg::LOAD;
            end else begin
                pc_f    <= pc_f + 1'b1;
                d_pc    <= pc_f;
                d_insn  <= i_imem_data;
                d_stall <= lc4_pkg::NONE;
                x_pc    <= d_pc;
                x_dec   <= d_dec;
                x_stall <= d_stall;
            end
            m_pc    <= x_pc;
            m_dec   <= x_dec;
            m_stall <= x_stall;
            w_pc    <= m_pc;
            w_dec   <= m_dec;
            w_stall <= m_stall;
            // a younger ALU op overrides a load leaving memory
            if (x_dec.nzp_we && !x_dec.is_load) begin
                nzp <= nzp_of(x_result);
            end else if (m_dec.is_load) begin
                nzp <= nzp_of(i_dmem_data);
            end
        end
    end

    always_ff @(posedge gwe) begin
        if (i_advance) begin
            x_rs  <= rf.rs_data;
            x_rt  <= rf.rt_data;
            m_alu <= x_result;
            m_rt  <= rt_fwd;
            w_alu <= m_alu;
            w_mem <= i_dmem_data;
        end
    end

    assign o_retire        = i_advance && (w_stall == lc4_pkg::NONE);
    assign o_trace_valid   = i_advance;
    assign o_trace_stall   = w_stall;
    assign o_trace_pc      = w_pc;
    assign o_trace_insn    = w_dec.insn;
    assign o_trace_rf_we   = w_dec.rf_we;
    assign o_trace_rf_wsel = w_dec.rd_sel;
    assign o_trace_rf_data = w_data;

endmodule

// ==== rtl/lc4_top.sv ====
`include "lc4_defines.svh"

module lc4_top (
    input  logic                        gwe,
    input  logic                        i_rst,
    output logic [`LC4_XLEN-1:0]        o_imem_addr,
    input  logic [`LC4_XLEN-1:0]        i_imem_data,
    output logic [`LC4_XLEN-1:0]        o_dmem_addr,
    input  logic [`LC4_XLEN-1:0]        i_dmem_data,
    output logic                        o_dmem_we,
    output logic [`LC4_XLEN-1:0]        o_dmem_wdata,
    input  logic                        i_psel,
    input  logic                        i_penable,
    input  logic                        i_pwrite,
    input  logic [`LC4_APB_ADDR_W-1:0]  i_paddr,
    input  logic [`LC4_XLEN-1:0]        i_pwdata,
    output logic [`LC4_XLEN-1:0]        o_prdata,
    output logic                        o_pready,
    output logic                        o_pslverr,
    output logic                        o_trace_valid,
    output logic [1:0]                  o_trace_stall,
    output logic [`LC4_XLEN-1:0]        o_trace_pc,
    output logic [`LC4_XLEN-1:0]        o_trace_insn,
    output logic                        o_trace_rf_we,
    output logic [`LC4_REG_SEL_W-1:0]   o_trace_rf_wsel,
    output logic [`LC4_XLEN-1:0]        o_trace_rf_data
);
    logic advance;
    logic retire;

    rf_if  rf ();
    apb_if apb ();

    assign apb.psel    = i_psel;
    assign apb.penable = i_penable;
    assign apb.pwrite  = i_pwrite;
    assign apb.paddr   = i_paddr;
    assign apb.pwdata  = i_pwdata;
    assign o_prdata    = apb.prdata;
    assign o_pready    = apb.pready;
    assign o_pslverr   = apb.pslverr;

    lc4_run_ctrl u_run_ctrl (
        .gwe       (gwe),
        .i_rst     (i_rst),
        .apb       (apb),
        .i_retire  (retire),
        .o_advance (advance)
    );

    lc4_regfile u_regfile (.gwe(gwe), .i_rst(i_rst), .rf(rf));

    lc4_pipeline u_pipeline (
        .gwe             (gwe),
        .i_rst           (i_rst),
        .i_advance       (advance),
        .o_imem_addr     (o_imem_addr),
        .i_imem_data     (i_imem_data),
        .o_dmem_addr     (o_dmem_addr),
        .i_dmem_data     (i_dmem_data),
        .o_dmem_we       (o_dmem_we),
        .o_dmem_wdata    (o_dmem_wdata),
        .rf              (rf),
        .o_retire        (retire),
        .o_trace_valid   (o_trace_valid),
        .o_trace_stall   (o_trace_stall),
        .o_trace_pc      (o_trace_pc),
        .o_trace_insn    (o_trace_insn),
        .o_trace_rf_we   (o_trace_rf_we),
        .o_trace_rf_wsel (o_trace_rf_wsel),
        .o_trace_rf_data (o_trace_rf_data)
    );

endmodule

// ==== verification/lc4_asserts.sv ====
module lc4_asserts (
    input logic       gwe,
    input logic       i_rst,
    input logic       i_advance,
    input logic       i_pready,
    input logic       i_dmem_we,
    input logic [1:0] i_trace_stall,
    input logic       i_trace_rf_we
);
    timeunit 1ns;
    timeprecision 1ps;

    // failures seen so far, picked up by the testbench at the end
    int fail_cnt = 0;

    // no wait states ever
    a_pready: assert property (@(posedge gwe) i_pready)
        else begin
            fail_cnt++;
            $error("APB pready went low");
        end

    // memory writes only happen on edges where the core moves
    a_dmem_we: assert property (@(posedge gwe) disable iff (i_rst) i_dmem_we |-> i_advance)
        else begin
            fail_cnt++;
            $error("data memory write while the pipeline was halted");
        end

    a_bubble: assert property (@(posedge gwe) disable iff (i_rst)
                               (i_trace_stall != 2'd0) |-> !i_trace_rf_we)
        else begin
            fail_cnt++;
            $error("a bubble in writeback wrote the register file");
        end

endmodule

bind lc4_top lc4_asserts u_asserts (
    .gwe           (gwe),
    .i_rst         (i_rst),
    .i_advance     (advance),
    .i_pready      (o_pready),
    .i_dmem_we     (o_dmem_we),
    .i_trace_stall (o_trace_stall),
    .i_trace_rf_we (o_trace_rf_we)
);

// ==== verification/lc4_tb.sv ====
`include "lc4_defines.svh"

module lc4_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PERIOD = 40;

    logic        gwe, i_rst;
    logic [15:0] o_imem_addr, i_imem_data, o_dmem_addr, i_dmem_data, o_dmem_wdata;
    logic        o_dmem_we;
    logic        i_psel, i_penable, i_pwrite;
    logic [3:0]  i_paddr;
    logic [15:0] i_pwdata, o_prdata;
    logic        o_pready, o_pslverr;
    logic        o_trace_valid, o_trace_rf_we;
    logic [1:0]  o_trace_stall;
    logic [15:0] o_trace_pc, o_trace_insn, o_trace_rf_data;
    logic [2:0]  o_trace_rf_wsel;

    logic [15:0] stim [0:511];
    logic [15:0] dmem [0:65535];
    int prog_len, trace_len, store_cnt, trace_base, store_base;
    int trace_idx = 0;
    int store_idx = 0;
    int err_cnt = 0;

    lc4_top UUT (.*);

    always #(PERIOD / 2) gwe = ~gwe;

    task automatic check_value(input string name, input logic [15:0] exp, input logic [15:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    // program words start at the reset PC and NOP fills the rest
    function automatic logic [15:0] fetch_word(input logic [15:0] addr);
        logic [15:0] off;
        off = addr - `LC4_RESET_PC;
        if (int'(off) < prog_len) return stim[3 + int'(off)];
        return 16'h0000;
    endfunction

    task automatic check_trace(input int idx);
        int b;
        b = trace_base + 7 * idx;
        check_value($sformatf("trace %0d stall", idx), stim[b + 1], {14'b0, o_trace_stall});
        check_value($sformatf("trace %0d pc", idx), stim[b + 2], o_trace_pc);
        check_value($sformatf("trace %0d insn", idx), stim[b + 3], o_trace_insn);
        check_value($sformatf("trace %0d rf_we", idx), stim[b + 4], {15'b0, o_trace_rf_we});
        // select and data only mean something on a write
        if (stim[b + 4][0]) begin
            check_value($sformatf("trace %0d wsel", idx), stim[b + 5], {13'b0, o_trace_rf_wsel});
            check_value($sformatf("trace %0d data", idx), stim[b + 6], o_trace_rf_data);
        end
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [15:0] data);
        @(negedge gwe);
        i_psel    = 1'b1;
        i_penable = 1'b0;
        i_pwrite  = 1'b1;
        i_paddr   = addr;
        i_pwdata  = data;
        @(negedge gwe);
        i_penable = 1'b1;
        @(negedge gwe);
        i_psel    = 1'b0;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [15:0] data, output logic err);
        @(negedge gwe);
        i_psel    = 1'b1;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
        i_paddr   = addr;
        @(negedge gwe);
        i_penable = 1'b1;
        #(PERIOD / 4);
        data = o_prdata;
        err  = o_pslverr;
        @(negedge gwe);
        i_psel    = 1'b0;
        i_penable = 1'b0;
    endtask

    // memory models and trace monitor run on the falling edge
    always @(negedge gwe) begin
        if (o_dmem_we) begin
            if (store_idx >= store_cnt) begin
                $display("store to %h beyond the expected list", o_dmem_addr);
                err_cnt++;
            end else begin
                check_value("store addr", stim[store_base + 2 * store_idx], o_dmem_addr);
                check_value("store data", stim[store_base + 2 * store_idx + 1], o_dmem_wdata);
            end
            store_idx++;
            dmem[o_dmem_addr] = o_dmem_wdata;
        end
        if (o_trace_valid) begin
            if (trace_idx >= trace_len) begin
                $display("trace cycle %0d beyond the expected trace", trace_idx);
                err_cnt++;
            end else begin
                check_trace(trace_idx);
            end
            trace_idx++;
        end
        i_dmem_data = dmem[o_dmem_addr];
        i_imem_data = fetch_word(o_imem_addr);
    end

    // allows for the APB traffic around the traced run
    initial begin
        #1;
        #((trace_len + 80) * PERIOD);
        $display("timeout, the run did not finish in time");
        $display("test failed");
        $finish;
    end

    initial begin
        logic [15:0] rd;
        logic        err;
        int          step_n;
        int          retired_exp;
        int          frozen_idx;
        logic [15:0] frozen_pc;
        gwe         = 1'b0;
        i_rst       = 1'b1;
        i_psel      = 1'b0;
        i_penable   = 1'b0;
        i_pwrite    = 1'b0;
        i_paddr     = '0;
        i_pwdata    = '0;
        i_imem_data = '0;
        i_dmem_data = '0;
        $readmemh("verification/lc4_stimulus.mem", stim);
        prog_len   = int'(stim[0]);
        trace_len  = int'(stim[1]);
        store_cnt  = int'(stim[2]);
        trace_base = 3 + prog_len;
        store_base = trace_base + 7 * trace_len;
        for (int i = 0; i < 65536; i++) begin
            dmem[i] = i[15:0] ^ 16'h5a5a;
        end
        repeat (3) @(negedge gwe);
        i_rst = 1'b0;

        // halted after reset
        repeat (10) @(negedge gwe);
        check_value("idle trace cycles", 16'd0, 16'(trace_idx));
        check_value("idle stores", 16'd0, 16'(store_idx));
        apb_read(`LC4_REG_CTRL, rd, err);
        check_value("reset CTRL", 16'd0, rd);
        check_value("reset pslverr", 16'd0, {15'b0, err});
        apb_read(`LC4_REG_STEP, rd, err);
        check_value("reset STEP", 16'd0, rd);
        apb_read(`LC4_REG_RETIRED, rd, err);
        check_value("reset RETIRED", 16'd0, rd);

        // free run for most of the trace and step the rest
        apb_write(`LC4_REG_CTRL, 16'd1);
        while (trace_idx < trace_len - 12) @(posedge gwe);
        apb_write(`LC4_REG_CTRL, 16'd0);
        #1;
        step_n = trace_len - trace_idx;
        apb_write(`LC4_REG_STEP, 16'(step_n));
        do begin
            apb_read(`LC4_REG_STEP, rd, err);
        end while (rd != 16'd0);
        check_value("traced lines after step", 16'(trace_len), 16'(trace_idx));

        frozen_idx = trace_idx;
        frozen_pc  = o_imem_addr;
        repeat (4) @(negedge gwe);
        check_value("frozen trace count", 16'(frozen_idx), 16'(trace_idx));
        check_value("frozen fetch pc", frozen_pc, o_imem_addr);
        check_value("store count", 16'(store_cnt), 16'(store_idx));

        retired_exp = 0;
        for (int i = 0; i < trace_len; i++) begin
            if (stim[trace_base + 7 * i + 1] == 16'(lc4_pkg::NONE)) retired_exp++;
        end
        apb_read(`LC4_REG_RETIRED, rd, err);
        check_value("RETIRED", 16'(retired_exp), rd);

        apb_read(4'hC, rd, err);
        check_value("unmapped pslverr", 16'd1, {15'b0, err});
        check_value("unmapped prdata", 16'd0, rd);

        err_cnt += UUT.u_asserts.fail_cnt;
        $display("errors %0d, trace lines %0d of %0d, stores %0d of %0d",
                 err_cnt, trace_idx, trace_len, store_idx, store_cnt);
        if (err_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== verification/lc4_stimulus.mem ====
// header: program length, trace length, store count, then program words from 8200
// trace lines: valid stall pc insn rf_we wsel data; store lines: address data
001B 0026 0004
9205 95FD 1642 18D1 1B27 5D41 5F88 51D1 5C1A 5E2C
9664 7EC1 68C1 1B04 7AC2 6CC2 7CC3 60C5 0202 9201
9202 C802 9203 9204 1206 0801 72C4
1 2 0000 0000 0 0 0000  1 2 0000 0000 0 0 0000
1 2 0000 0000 0 0 0000  1 2 0000 0000 0 0 0000
1 0 8200 9205 1 1 0005  1 0 8201 95FD 1 2 FFFD
1 0 8202 1642 1 3 0002  1 0 8203 18D1 1 4 FFFD
1 0 8204 1B27 1 5 0004  1 0 8205 5D41 1 6 0004
1 0 8206 5F88 1 7 FFFB  1 0 8207 51D1 1 0 FFFF
1 0 8208 5C1A 1 6 0002  1 0 8209 5E2C 1 7 000C
1 0 820A 9664 1 3 0064  1 0 820B 7EC1 0 0 0000
1 0 820C 68C1 1 4 000C  1 3 0000 0000 0 0 0000
1 0 820D 1B04 1 5 0018  1 0 820E 7AC2 0 0 0000
1 0 820F 6CC2 1 6 0018  1 0 8210 7CC3 0 0 0000
1 0 8211 60C5 1 0 5A33  1 3 0000 0000 0 0 0000
1 0 8212 0202 0 0 0000  1 2 0000 0000 0 0 0000
1 2 0000 0000 0 0 0000  1 0 8215 C802 0 0 0000
1 2 0000 0000 0 0 0000  1 2 0000 0000 0 0 0000
1 0 8218 1206 1 1 5A4B  1 0 8219 0801 0 0 0000
1 0 821A 72C4 0 0 0000  1 0 821B 0000 0 0 0000
1 0 821C 0000 0 0 0000  1 0 821D 0000 0 0 0000
1 0 821E 0000 0 0 0000  1 0 821F 0000 0 0 0000
0065 000C  0066 0018  0067 0018  0068 5A4B

// ==== compile.f ====
+incdir+rtl
rtl/lc4_pkg.sv
rtl/lc4_ifs.sv
rtl/lc4_decoder.sv
rtl/lc4_alu.sv
rtl/lc4_regfile.sv
rtl/lc4_run_ctrl.sv
rtl/lc4_pipeline.sv
rtl/lc4_top.sv
verification/lc4_asserts.sv
verification/lc4_tb.sv

// ==== Makefile ====
.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module lc4_tb -o sim
	./obj_dir/sim +verilator+error+limit+100 | tee /dev/stderr | grep -qx "test passed"

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module lc4_tb

clean:
	rm -rf obj_dir
